// File: exec_pkg.sv
`default_nettype none

package exec_pkg;

    typedef logic [31:0] word_t;

    // hi in [63:32], lo in [31:0]
    typedef logic [63:0] dword_t;

    typedef logic [15:0] imm_t;

    typedef enum logic [4:0] {
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        LUI,
        MULT,
        MULTU,
        DIV,
        DIVU,
        NOP
    } exec_op_e;

    typedef enum logic {
        REGB,
        IMM
    } src_sel_e;

    // nine kinds, so four bits
    typedef enum logic [3:0] {
        NONE,
        BEQ,
        BNE,
        BLEZ,
        BGTZ,
        BLTZ,
        BGEZ,
        J,
        JR
    } branch_kind_e;

    function automatic logic is_muldiv(exec_op_e op);
        return (op == MULT) || (op == MULTU) || (op == DIV) || (op == DIVU);
    endfunction

endpackage

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu (
    input  exec_pkg::word_t    a_i,
    input  exec_pkg::word_t    b_i,
    input  logic [4:0]         shamt_i,
    input  exec_pkg::exec_op_e op_i,
    output exec_pkg::word_t    result_o,
    output logic               ovf_o
);
    import exec_pkg::*;

    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;

    // operands agree in sign, result does not
    assign add_ovf = (a_i[31] == b_i[31]) && (sum[31] != a_i[31]);
    // operands differ in sign, result takes the sign of b
    assign sub_ovf = (a_i[31] != b_i[31]) && (diff[31] != a_i[31]);

    always_comb begin
        result_o = '0;
        case (op_i)
            ADD, ADDU: result_o = sum;
            SUB, SUBU: result_o = diff;
            AND:       result_o = a_i & b_i;
            OR:        result_o = a_i | b_i;
            XOR:       result_o = a_i ^ b_i;
            NOR:       result_o = ~(a_i | b_i);
            SLT:       result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            SLTU:      result_o = {31'b0, a_i < b_i};
            // shifts work on rt
            SLL:       result_o = b_i << shamt_i;
            SRL:       result_o = b_i >> shamt_i;
            SRA:       result_o = word_t'($signed(b_i) >>> shamt_i);
            LUI:       result_o = {b_i[15:0], 16'h0000};
            // mul/div and nop leave the result at zero
            default:   result_o = '0;
        endcase
    end

    // unsigned forms never trap
    assign ovf_o = ((op_i == ADD) && add_ovf) || ((op_i == SUB) && sub_ovf);

endmodule

`default_nettype wire

// File: branch_unit.sv
`default_nettype none

module branch_unit (
    input  exec_pkg::branch_kind_e kind_i,
    input  exec_pkg::word_t        rs_i,
    input  exec_pkg::word_t        rt_i,
    input  exec_pkg::word_t        pc_i,
    input  exec_pkg::imm_t         offset_i,
    input  logic [25:0]            instr_index_i,
    output logic                   taken_o,
    output exec_pkg::word_t        target_o
);
    import exec_pkg::*;

    word_t slot_pc;
    word_t br_target;
    word_t j_target;
    logic  rs_zero;
    logic  rs_neg;

    // delay slot address
    assign slot_pc   = pc_i + 32'd4;
    assign br_target = slot_pc + {{14{offset_i[15]}}, offset_i, 2'b00};
    assign j_target  = {slot_pc[31:28], instr_index_i, 2'b00};

    assign rs_zero = (rs_i == '0);
    assign rs_neg  = rs_i[31];

    always_comb begin
        taken_o  = 1'b0;
        target_o = '0;
        case (kind_i)
            BEQ: begin
                taken_o  = (rs_i == rt_i);
                target_o = br_target;
            end
            BNE: begin
                taken_o  = (rs_i != rt_i);
                target_o = br_target;
            end
            BLEZ: begin
                taken_o  = rs_neg || rs_zero;
                target_o = br_target;
            end
            BGTZ: begin
                taken_o  = !rs_neg && !rs_zero;
                target_o = br_target;
            end
            BLTZ: begin
                taken_o  = rs_neg;
                target_o = br_target;
            end
            BGEZ: begin
                taken_o  = !rs_neg;
                target_o = br_target;
            end
            J: begin
                taken_o  = 1'b1;
                target_o = j_target;
            end
            JR: begin
                taken_o  = 1'b1;
                target_o = rs_i;
            end
            default: begin
                taken_o  = 1'b0;
                target_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: mult_unit.sv
`default_nettype none

module mult_unit (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             start_i,
    input  logic             signed_i,
    input  exec_pkg::word_t  a_i,
    input  exec_pkg::word_t  b_i,
    output logic             done_o,
    output exec_pkg::dword_t product_o
);
    import exec_pkg::*;

    logic        busy;
    logic [4:0]  step;
    logic        negate;
    word_t       mcand;
    dword_t      acc;
    dword_t      acc_next;
    logic [32:0] upper_sum;
    word_t       a_mag;
    word_t       b_mag;

    assign a_mag = (signed_i && a_i[31]) ? -a_i : a_i;
    assign b_mag = (signed_i && b_i[31]) ? -b_i : b_i;

    // acc holds {partial product, remaining multiplier bits}
    assign upper_sum = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, mcand} : 33'd0);
    assign acc_next  = {upper_sum, acc[31:1]};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy   <= 1'b0;
            step   <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (busy) begin
                step <= step + 5'd1;
                if (step == 5'd31) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end else if (start_i) begin
                busy <= 1'b1;
                step <= '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (busy) begin
            acc <= acc_next;
            // last step, apply the sign
            if (step == 5'd31) begin
                product_o <= negate ? -acc_next : acc_next;
            end
        end else if (start_i) begin
            mcand  <= a_mag;
            acc    <= {32'b0, b_mag};
            negate <= signed_i && (a_i[31] ^ b_i[31]);
        end
    end

endmodule

`default_nettype wire

// File: div_unit.sv
`default_nettype none

module div_unit (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             start_i,
    input  logic             signed_i,
    input  exec_pkg::word_t  a_i,
    input  exec_pkg::word_t  b_i,
    output logic             done_o,
    output exec_pkg::dword_t quot_rem_o
);
    import exec_pkg::*;

    logic        busy;
    logic [4:0]  step;
    logic        quot_neg;
    logic        rem_neg;
    word_t       divisor;
    word_t       rem;
    word_t       quot;
    logic [32:0] rem_shift;
    logic [32:0] trial;
    word_t       rem_next;
    word_t       quot_next;
    word_t       a_mag;
    word_t       b_mag;

    assign a_mag = (signed_i && a_i[31]) ? -a_i : a_i;
    assign b_mag = (signed_i && b_i[31]) ? -b_i : b_i;

    // quot starts as the dividend and fills with quotient bits from the right
    assign rem_shift = {rem, quot[31]};
    assign trial     = rem_shift - {1'b0, divisor};

    // negative trial means restore
    assign rem_next  = trial[32] ? rem_shift[31:0] : trial[31:0];
    assign quot_next = {quot[30:0], ~trial[32]};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy   <= 1'b0;
            step   <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (busy) begin
                step <= step + 5'd1;
                if (step == 5'd31) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end else if (start_i) begin
                busy <= 1'b1;
                step <= '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (busy) begin
            rem  <= rem_next;
            quot <= quot_next;
            if (step == 5'd31) begin
                quot_rem_o <= {rem_neg ? -rem_next : rem_next,
                               quot_neg ? -quot_next : quot_next};
            end
        end else if (start_i) begin
            divisor  <= b_mag;
            rem      <= '0;
            quot     <= a_mag;
            quot_neg <= signed_i && (a_i[31] ^ b_i[31]);
            // remainder follows the dividend
            rem_neg  <= signed_i && a_i[31];
        end
    end

endmodule

`default_nettype wire

// File: muldiv_arbiter.sv
`default_nettype none

module muldiv_arbiter (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               req0_i,
    input  logic               req1_i,
    input  exec_pkg::exec_op_e op0_i,
    input  exec_pkg::exec_op_e op1_i,
    input  exec_pkg::word_t    rs0_i,
    input  exec_pkg::word_t    rt0_i,
    input  exec_pkg::word_t    rs1_i,
    input  exec_pkg::word_t    rt1_i,
    output logic               stall_o,
    output exec_pkg::dword_t   hilo0_o,
    output exec_pkg::dword_t   hilo1_o,
    output logic               hilo0_we_o,
    output logic               hilo1_we_o
);
    import exec_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN1,
        ST_RUN0,
        ST_FINISH
    } arb_state_e;

    arb_state_e state;
    logic       pend0;
    logic       pend1;
    logic       want0;
    logic       want1;
    logic       grant1;
    logic       start;
    logic       grant_signed;
    logic       grant_mult;
    exec_op_e   grant_op;
    word_t      grant_a;
    word_t      grant_b;
    logic       mult_done;
    logic       div_done;
    logic       unit_done;
    dword_t     product;
    dword_t     quot_rem;
    dword_t     unit_result;

    assign want0 = req0_i && is_muldiv(op0_i);
    assign want1 = req1_i && is_muldiv(op1_i);

    // lane 1 goes first from idle, lane 0 follows when lane 1 finishes
    assign grant1 = (state == ST_IDLE) && want1;
    assign start  = ((state == ST_IDLE) && (want0 || want1)) ||
                    ((state == ST_RUN1) && unit_done && pend0);

    assign grant_op     = grant1 ? op1_i : op0_i;
    assign grant_a      = grant1 ? rs1_i : rs0_i;
    assign grant_b      = grant1 ? rt1_i : rt0_i;
    assign grant_signed = (grant_op == MULT) || (grant_op == DIV);
    assign grant_mult   = (grant_op == MULT) || (grant_op == MULTU);

    assign unit_done   = mult_done || div_done;
    assign unit_result = mult_done ? product : quot_rem;

    // finish cycle drops the stall while the old op is still on the inputs
    assign stall_o    = (state == ST_IDLE) ? (want0 || want1) : (state != ST_FINISH);
    assign hilo0_we_o = (state == ST_FINISH) && pend0;
    assign hilo1_we_o = (state == ST_FINISH) && pend1;

    mult_unit u_mult (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .start_i   (start && grant_mult),
        .signed_i  (grant_signed),
        .a_i       (grant_a),
        .b_i       (grant_b),
        .done_o    (mult_done),
        .product_o (product)
    );

    div_unit u_div (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .start_i    (start && !grant_mult),
        .signed_i   (grant_signed),
        .a_i        (grant_a),
        .b_i        (grant_b),
        .done_o     (div_done),
        .quot_rem_o (quot_rem)
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= ST_IDLE;
            pend0 <= 1'b0;
            pend1 <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (want0 || want1) begin
                        pend0 <= want0;
                        pend1 <= want1;
                        state <= want1 ? ST_RUN1 : ST_RUN0;
                    end
                end
                ST_RUN1: begin
                    if (unit_done) begin
                        state <= pend0 ? ST_RUN0 : ST_FINISH;
                    end
                end
                ST_RUN0: begin
                    if (unit_done) begin
                        state <= ST_FINISH;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (unit_done && (state == ST_RUN1)) begin
            hilo1_o <= unit_result;
        end
        if (unit_done && (state == ST_RUN0)) begin
            hilo0_o <= unit_result;
        end
    end

endmodule

`default_nettype wire

// File: exec_stage.sv
`default_nettype none

module exec_stage (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  logic                   lane0_valid_i,
    input  exec_pkg::exec_op_e     lane0_op_i,
    input  exec_pkg::word_t        lane0_rs_i,
    input  exec_pkg::word_t        lane0_rt_i,
    input  exec_pkg::imm_t         lane0_imm_i,
    input  logic                   lane0_zeroext_i,
    input  exec_pkg::src_sel_e     lane0_alusrc_i,
    input  exec_pkg::word_t        lane0_pc_i,

    input  logic                   lane1_valid_i,
    input  exec_pkg::exec_op_e     lane1_op_i,
    input  exec_pkg::word_t        lane1_rs_i,
    input  exec_pkg::word_t        lane1_rt_i,
    input  exec_pkg::imm_t         lane1_imm_i,
    input  logic                   lane1_zeroext_i,
    input  exec_pkg::src_sel_e     lane1_alusrc_i,
    input  exec_pkg::word_t        lane1_pc_i,
    input  exec_pkg::branch_kind_e lane1_branch_i,
    input  logic                   lane1_link_i,
    input  logic [25:0]            lane1_instr_index_i,

    output exec_pkg::word_t        lane0_result_o,
    output exec_pkg::word_t        lane1_result_o,
    output logic                   lane0_ovf_o,
    output logic                   lane1_ovf_o,
    output logic                   lane0_kill_o,
    output logic                   branch_taken_o,
    output exec_pkg::word_t        branch_target_o,
    output exec_pkg::dword_t       lane0_hilo_o,
    output exec_pkg::dword_t       lane1_hilo_o,
    output logic                   lane0_hilo_we_o,
    output logic                   lane1_hilo_we_o,
    output logic                   stall_o
);
    import exec_pkg::*;

    word_t lane0_b;
    word_t lane1_b;
    word_t lane1_alu_result;
    logic  lane0_req;
    logic  lane1_req;

    function automatic word_t extend_imm(imm_t imm, logic zero_ext);
        return zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
    endfunction

    assign lane0_b = (lane0_alusrc_i == IMM) ? extend_imm(lane0_imm_i, lane0_zeroext_i)
                                             : lane0_rt_i;
    assign lane1_b = (lane1_alusrc_i == IMM) ? extend_imm(lane1_imm_i, lane1_zeroext_i)
                                             : lane1_rt_i;

    // shift amount sits in imm[10:6]
    alu u_alu0 (
        .a_i      (lane0_rs_i),
        .b_i      (lane0_b),
        .shamt_i  (lane0_imm_i[10:6]),
        .op_i     (lane0_op_i),
        .result_o (lane0_result_o),
        .ovf_o    (lane0_ovf_o)
    );

    alu u_alu1 (
        .a_i      (lane1_rs_i),
        .b_i      (lane1_b),
        .shamt_i  (lane1_imm_i[10:6]),
        .op_i     (lane1_op_i),
        .result_o (lane1_alu_result),
        .ovf_o    (lane1_ovf_o)
    );

    // link skips the delay slot
    assign lane1_result_o = lane1_link_i ? (lane1_pc_i + 32'd8) : lane1_alu_result;

    // older lane traps, younger lane must not commit
    assign lane0_kill_o = lane1_valid_i && lane1_ovf_o;

    branch_unit u_branch (
        .kind_i        (lane1_branch_i),
        .rs_i          (lane1_rs_i),
        .rt_i          (lane1_rt_i),
        .pc_i          (lane1_pc_i),
        .offset_i      (lane1_imm_i),
        .instr_index_i (lane1_instr_index_i),
        .taken_o       (branch_taken_o),
        .target_o      (branch_target_o)
    );

    assign lane0_req = lane0_valid_i && is_muldiv(lane0_op_i);
    assign lane1_req = lane1_valid_i && is_muldiv(lane1_op_i);

    muldiv_arbiter u_muldiv (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req0_i     (lane0_req),
        .req1_i     (lane1_req),
        .op0_i      (lane0_op_i),
        .op1_i      (lane1_op_i),
        .rs0_i      (lane0_rs_i),
        .rt0_i      (lane0_rt_i),
        .rs1_i      (lane1_rs_i),
        .rt1_i      (lane1_rt_i),
        .stall_o    (stall_o),
        .hilo0_o    (lane0_hilo_o),
        .hilo1_o    (lane1_hilo_o),
        .hilo0_we_o (lane0_hilo_we_o),
        .hilo1_we_o (lane1_hilo_we_o)
    );

endmodule

`default_nettype wire

// File: tb_exec_model.svh
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h27250af8;

function automatic logic rand_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic word_t rand_bits(int unsigned n);
    word_t r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
        r = {r[30:0], rand_bit()};
    end
    return r;
endfunction

function automatic word_t ref_operand_b(src_sel_e sel, word_t rt, imm_t imm, logic zext);
    if (sel == REGB) begin
        return rt;
    end
    if (zext) begin
        return {16'h0000, imm};
    end
    return {{16{imm[15]}}, imm};
endfunction

// {ovf, result}
function automatic logic [32:0] ref_alu(exec_op_e op, word_t a, word_t b, logic [4:0] shamt);
    logic [32:0]        wide;
    logic signed [31:0] sb;
    word_t              r;
    logic               v;
    r = '0;
    v = 1'b0;
    sb = b;
    case (op)
        ADD: begin
            wide = {a[31], a} + {b[31], b};
            r = wide[31:0];
            v = wide[32] ^ wide[31];
        end
        SUB: begin
            wide = {a[31], a} - {b[31], b};
            r = wide[31:0];
            v = wide[32] ^ wide[31];
        end
        ADDU:    r = a + b;
        SUBU:    r = a - b;
        AND:     r = a & b;
        OR:      r = a | b;
        XOR:     r = a ^ b;
        NOR:     r = ~(a | b);
        SLT:     r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        SLTU:    r = (a < b) ? 32'd1 : 32'd0;
        SLL:     r = b << shamt;
        SRL:     r = b >> shamt;
        SRA:     r = sb >>> shamt;
        LUI:     r = {b[15:0], 16'h0000};
        default: r = '0;
    endcase
    return {v, r};
endfunction

// {taken, target}
function automatic logic [32:0] ref_branch(branch_kind_e kind, word_t rs, word_t rt, word_t pc,
                                           imm_t off, logic [25:0] idx);
    word_t              next_pc;
    word_t              tgt;
    logic               tk;
    logic signed [31:0] srs;
    logic signed [31:0] soff;
    next_pc = pc + 32'd4;
    srs = rs;
    soff = {{16{off[15]}}, off};
    tk = 1'b0;
    tgt = next_pc + word_t'(soff * 32'sd4);
    case (kind)
        BEQ:  tk = (rs == rt);
        BNE:  tk = (rs != rt);
        BLEZ: tk = (srs <= 32'sd0);
        BGTZ: tk = (srs > 32'sd0);
        BLTZ: tk = (srs < 32'sd0);
        BGEZ: tk = (srs >= 32'sd0);
        J: begin
            tk = 1'b1;
            tgt = {next_pc[31:28], idx, 2'b00};
        end
        JR: begin
            tk = 1'b1;
            tgt = rs;
        end
        default: tgt = '0;
    endcase
    return {tk, tgt};
endfunction

function automatic logic ref_is_md(exec_op_e op);
    return op inside {MULT, MULTU, DIV, DIVU};
endfunction

// hi is the remainder for divides
function automatic dword_t ref_muldiv(exec_op_e op, word_t rs, word_t rt);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] sq;
    logic signed [63:0] sm;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        uq;
    logic [63:0]        um;
    dword_t             res;
    sa = {{32{rs[31]}}, rs};
    sb = {{32{rt[31]}}, rt};
    ua = {32'h0, rs};
    ub = {32'h0, rt};
    res = '0;
    case (op)
        MULT: begin
            sq = sa * sb;
            res = sq;
        end
        MULTU: res = ua * ub;
        DIV: begin
            sq = sa / sb;
            sm = sa % sb;
            res = {sm[31:0], sq[31:0]};
        end
        DIVU: begin
            uq = ua / ub;
            um = ua % ub;
            res = {um[31:0], uq[31:0]};
        end
        default: res = '0;
    endcase
    return res;
endfunction

`endif

// File: tb_exec.sv
`default_nettype none

module tb_exec;
    import exec_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int MD_TIMEOUT  = 200;
    localparam int MODE_OFF    = 0;
    localparam int MODE_COMB   = 1;
    localparam int MODE_MULDIV = 2;

    logic         clk_i = 1'b0;
    logic         rst_n_i;
    logic         lane0_valid_i;
    exec_op_e     lane0_op_i;
    word_t        lane0_rs_i;
    word_t        lane0_rt_i;
    imm_t         lane0_imm_i;
    logic         lane0_zeroext_i;
    src_sel_e     lane0_alusrc_i;
    word_t        lane0_pc_i;
    logic         lane1_valid_i;
    exec_op_e     lane1_op_i;
    word_t        lane1_rs_i;
    word_t        lane1_rt_i;
    imm_t         lane1_imm_i;
    logic         lane1_zeroext_i;
    src_sel_e     lane1_alusrc_i;
    word_t        lane1_pc_i;
    branch_kind_e lane1_branch_i;
    logic         lane1_link_i;
    logic [25:0]  lane1_instr_index_i;

    word_t  lane0_result_o;
    word_t  lane1_result_o;
    logic   lane0_ovf_o;
    logic   lane1_ovf_o;
    logic   lane0_kill_o;
    logic   branch_taken_o;
    word_t  branch_target_o;
    dword_t lane0_hilo_o;
    dword_t lane1_hilo_o;
    logic   lane0_hilo_we_o;
    logic   lane1_hilo_we_o;
    logic   stall_o;

    word_t  exp_result0;
    word_t  exp_result1;
    logic   exp_ovf0;
    logic   exp_ovf1;
    logic   exp_kill;
    logic   exp_taken;
    word_t  exp_target;
    logic   exp_we0;
    logic   exp_we1;
    dword_t exp_hilo0;
    dword_t exp_hilo1;
    string  test_name;
    int     check_mode = MODE_OFF;

    // md_id is bumped by stimulus, the rest belong to the compare process
    int md_id = 0;
    int md_seen_id = 0;
    int md_done_id = 0;
    int md_cycles = 0;

    `include "tb_exec_model.svh"

    exec_stage dut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic start_slot();
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic drive_nop();
        lane0_valid_i = 1'b0;
        lane0_op_i = NOP;
        lane0_rs_i = '0;
        lane0_rt_i = '0;
        lane0_imm_i = '0;
        lane0_zeroext_i = 1'b0;
        lane0_alusrc_i = REGB;
        lane0_pc_i = '0;
        lane1_valid_i = 1'b0;
        lane1_op_i = NOP;
        lane1_rs_i = '0;
        lane1_rt_i = '0;
        lane1_imm_i = '0;
        lane1_zeroext_i = 1'b0;
        lane1_alusrc_i = REGB;
        lane1_pc_i = '0;
        lane1_branch_i = NONE;
        lane1_link_i = 1'b0;
        lane1_instr_index_i = '0;
    endtask

    task automatic set_expected();
        logic [32:0] a0;
        logic [32:0] a1;
        logic [32:0] br;
        word_t       b0;
        word_t       b1;
        b0 = ref_operand_b(lane0_alusrc_i, lane0_rt_i, lane0_imm_i, lane0_zeroext_i);
        b1 = ref_operand_b(lane1_alusrc_i, lane1_rt_i, lane1_imm_i, lane1_zeroext_i);
        a0 = ref_alu(lane0_op_i, lane0_rs_i, b0, lane0_imm_i[10:6]);
        a1 = ref_alu(lane1_op_i, lane1_rs_i, b1, lane1_imm_i[10:6]);
        exp_result0 = a0[31:0];
        exp_ovf0 = a0[32];
        exp_result1 = lane1_link_i ? lane1_pc_i + 32'd8 : a1[31:0];
        exp_ovf1 = a1[32];
        exp_kill = lane1_valid_i && a1[32];
        br = ref_branch(lane1_branch_i, lane1_rs_i, lane1_rt_i, lane1_pc_i, lane1_imm_i,
                        lane1_instr_index_i);
        exp_taken = br[32];
        exp_target = br[31:0];
        exp_we0 = lane0_valid_i && ref_is_md(lane0_op_i);
        exp_we1 = lane1_valid_i && ref_is_md(lane1_op_i);
        exp_hilo0 = ref_muldiv(lane0_op_i, lane0_rs_i, lane0_rt_i);
        exp_hilo1 = ref_muldiv(lane1_op_i, lane1_rs_i, lane1_rt_i);
    endtask

    task automatic random_lane(output logic valid, output exec_op_e op, output word_t rs,
                               output word_t rt, output imm_t imm, output logic zext,
                               output src_sel_e sel, output word_t pc);
        valid = rand_bit();
        // ADD through LUI only
        op = exec_op_e'(5'(rand_bits(4) % 32'd14));
        rs = rand_bits(32);
        rt = rand_bits(32);
        imm = 16'(rand_bits(16));
        zext = rand_bit();
        sel = src_sel_e'(rand_bit());
        pc = {30'(rand_bits(30)), 2'b00};
    endtask

    task automatic overflow_lane(output exec_op_e op, output word_t a, output word_t b);
        logic neg;
        neg = rand_bit();
        op = rand_bit() ? SUB : ADD;
        // large magnitudes of the chosen signs
        a = neg ? {2'b10, 30'(rand_bits(30))} : {2'b01, 30'(rand_bits(30))};
        if (op == ADD) begin
            b = neg ? {2'b10, 30'(rand_bits(30))} : {2'b01, 30'(rand_bits(30))};
        end else begin
            b = neg ? {2'b01, 30'(rand_bits(30))} : {2'b10, 30'(rand_bits(30))};
        end
    endtask

    task automatic muldiv_lane(output exec_op_e op, output word_t rs, output word_t rt);
        op = exec_op_e'(5'(MULT) + 5'(rand_bits(2)));
        rs = rand_bits(32);
        rt = rand_bits(32);
        if ((op == DIV || op == DIVU) && rt == '0) begin
            rt = 32'd1;
        end
    endtask

    // inputs stay put until stall_o falls
    task automatic run_muldiv();
        int n;
        set_expected();
        md_id = md_id + 1;
        check_mode = MODE_MULDIV;
        n = 0;
        while (md_done_id != md_id && n < MD_TIMEOUT) begin
            @(posedge clk_i);
            n++;
        end
        if (md_done_id != md_id) begin
            $display("timeout: stall_o did not fall during %s", test_name);
            $display("ERRORS FOUND");
            $fatal(1, "stall timeout");
        end
        #DRIVE_DELAY;
        drive_nop();
        set_expected();
        check_mode = MODE_COMB;
    endtask

    initial begin
        forever begin
            @(posedge clk_i);
            #(CLK_PERIOD - 1);
            if (check_mode == MODE_COMB) begin
                check_value("lane0_result", 64'(exp_result0), 64'(lane0_result_o));
                check_value("lane1_result", 64'(exp_result1), 64'(lane1_result_o));
                check_value("lane0_ovf", 64'(exp_ovf0), 64'(lane0_ovf_o));
                check_value("lane1_ovf", 64'(exp_ovf1), 64'(lane1_ovf_o));
                check_value("lane0_kill", 64'(exp_kill), 64'(lane0_kill_o));
                check_value("branch_taken", 64'(exp_taken), 64'(branch_taken_o));
                check_value("branch_target", 64'(exp_target), 64'(branch_target_o));
                check_value("stall", 64'd0, 64'(stall_o));
                check_value("lane0_hilo_we", 64'd0, 64'(lane0_hilo_we_o));
                check_value("lane1_hilo_we", 64'd0, 64'(lane1_hilo_we_o));
            end else if (check_mode == MODE_MULDIV && md_done_id != md_id) begin
                if (md_seen_id != md_id) begin
                    md_seen_id = md_id;
                    md_cycles = 0;
                end
                if (md_cycles == 0) begin
                    check_value("stall rise", 64'd1, 64'(stall_o));
                end else if (!stall_o) begin
                    check_value("lane0_hilo_we", 64'(exp_we0), 64'(lane0_hilo_we_o));
                    check_value("lane1_hilo_we", 64'(exp_we1), 64'(lane1_hilo_we_o));
                    if (exp_we0) begin
                        check_value("lane0_hilo", exp_hilo0, lane0_hilo_o);
                    end
                    if (exp_we1) begin
                        check_value("lane1_hilo", exp_hilo1, lane1_hilo_o);
                    end
                    md_done_id = md_id;
                end else begin
                    check_value("lane0_hilo_we early", 64'd0, 64'(lane0_hilo_we_o));
                    check_value("lane1_hilo_we early", 64'd0, 64'(lane1_hilo_we_o));
                end
                md_cycles++;
            end
        end
    end

    initial begin
        drive_nop();
        rst_n_i = 1'b0;
        test_name = "reset_idle";
        repeat (2) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;
        set_expected();
        check_mode = MODE_COMB;
        repeat (4) begin
            start_slot();
            drive_nop();
            set_expected();
        end

        test_name = "alu_random";
        repeat (300) begin
            start_slot();
            drive_nop();
            random_lane(lane0_valid_i, lane0_op_i, lane0_rs_i, lane0_rt_i, lane0_imm_i,
                        lane0_zeroext_i, lane0_alusrc_i, lane0_pc_i);
            random_lane(lane1_valid_i, lane1_op_i, lane1_rs_i, lane1_rt_i, lane1_imm_i,
                        lane1_zeroext_i, lane1_alusrc_i, lane1_pc_i);
            set_expected();
        end

        test_name = "overflow";
        repeat (100) begin
            start_slot();
            drive_nop();
            lane0_valid_i = rand_bit();
            lane1_valid_i = rand_bit();
            overflow_lane(lane0_op_i, lane0_rs_i, lane0_rt_i);
            overflow_lane(lane1_op_i, lane1_rs_i, lane1_rt_i);
            set_expected();
        end

        test_name = "branch";
        repeat (200) begin
            start_slot();
            drive_nop();
            random_lane(lane0_valid_i, lane0_op_i, lane0_rs_i, lane0_rt_i, lane0_imm_i,
                        lane0_zeroext_i, lane0_alusrc_i, lane0_pc_i);
            random_lane(lane1_valid_i, lane1_op_i, lane1_rs_i, lane1_rt_i, lane1_imm_i,
                        lane1_zeroext_i, lane1_alusrc_i, lane1_pc_i);
            lane1_branch_i = branch_kind_e'(4'(rand_bits(3) + 32'd1));
            if (rand_bits(3) == 32'd0) begin
                lane1_rs_i = '0;
            end
            if (rand_bit()) begin
                lane1_rt_i = lane1_rs_i;
            end
            lane1_link_i = rand_bit();
            lane1_instr_index_i = 26'(rand_bits(26));
            set_expected();
        end

        test_name = "muldiv_single";
        repeat (30) begin
            start_slot();
            drive_nop();
            if (rand_bit()) begin
                lane1_valid_i = 1'b1;
                muldiv_lane(lane1_op_i, lane1_rs_i, lane1_rt_i);
            end else begin
                lane0_valid_i = 1'b1;
                muldiv_lane(lane0_op_i, lane0_rs_i, lane0_rt_i);
            end
            run_muldiv();
        end

        test_name = "muldiv_dual";
        repeat (20) begin
            start_slot();
            drive_nop();
            lane0_valid_i = 1'b1;
            lane1_valid_i = 1'b1;
            muldiv_lane(lane0_op_i, lane0_rs_i, lane0_rt_i);
            muldiv_lane(lane1_op_i, lane1_rs_i, lane1_rt_i);
            run_muldiv();
        end

        start_slot();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
exec_pkg.sv
alu.sv
branch_unit.sv
mult_unit.sv
div_unit.sv
muldiv_arbiter.sv
exec_stage.sv
tb_exec.sv

// File: run.sh
#!/usr/bin/env bash
# builds the exec stage testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_exec -f list.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_exec
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished with status 0"
exit 0
